/* common/rate_ctrl_defs.svh */
// Body rate loop constants
// Fixed-point widths, PID gains and shifts, output and integral limits

`ifndef RATE_CTRL_DEFS_SVH
`define RATE_CTRL_DEFS_SVH

// Datapath widths, rates are 12.4 fixed point
`define RATE_W          16
`define OPS_W           32
`define FIXED_SHIFT     4

// Command saturation, 250 deg/s
`define RATE_LIMIT      (250 << `FIXED_SHIFT)

// Integral accumulator clamp
`define INT_LIMIT       (4000 << `FIXED_SHIFT)

// Yaw gains
`define YAW_K_P         48
`define YAW_K_I         0
`define YAW_K_D         5
`define YAW_K_P_SHIFT   4
`define YAW_K_I_SHIFT   4
`define YAW_K_D_SHIFT   4

// Roll gains
`define ROLL_K_P        5
`define ROLL_K_I        3
`define ROLL_K_D        4
`define ROLL_K_P_SHIFT  4
`define ROLL_K_I_SHIFT  4
`define ROLL_K_D_SHIFT  4

// Pitch gains
`define PITCH_K_P       5
`define PITCH_K_I       3
`define PITCH_K_D       4
`define PITCH_K_P_SHIFT 4
`define PITCH_K_I_SHIFT 4
`define PITCH_K_D_SHIFT 4

`endif

/* common/rate_ctrl_pkg.sv */
// Body rate loop types
// Rate and operand vectors, per-axis structs and FSM state encodings

`include "rate_ctrl_defs.svh"

package rate_ctrl_pkg;

	// Signed 12.4 rate
	typedef logic signed [`RATE_W-1:0] rate_t;

	// Wide signed operand for products and sums
	typedef logic signed [`OPS_W-1:0] ops_t;

	// One value per body axis
	typedef struct packed {
		rate_t yaw;
		rate_t roll;
		rate_t pitch;
	} axis_rates_t;

	// Angle errors from the angle loop, yaw has none
	typedef struct packed {
		rate_t roll;
		rate_t pitch;
	} angle_err_t;

	// Loop sequencing
	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_RUN,
		CTRL_DONE
	} ctrl_state_e;

	// PID calculation steps
	typedef enum logic [2:0] {
		PID_IDLE,
		PID_ERR,
		PID_TERMS,
		PID_SUM,
		PID_SAT
	} pid_state_e;

endpackage

/* hdl/rate_sample_latch.sv */
// Input sample stage of the rate loop
// Catches the start rise, holds the inputs for the cycle and flips
// the IMU yaw and pitch rates into the body frame

module rate_sample_latch (
	input  logic                       us_clk,
	input  logic                       resetn,
	input  logic                       start,
	input  rate_ctrl_pkg::axis_rates_t target,
	input  rate_ctrl_pkg::axis_rates_t imu_rate,
	input  rate_ctrl_pkg::angle_err_t  angle_err,
	input  logic                       busy,
	output rate_ctrl_pkg::axis_rates_t latched_target,
	output rate_ctrl_pkg::axis_rates_t latched_imu,
	output rate_ctrl_pkg::angle_err_t  latched_err,
	output logic                       sample
);

	logic start_q;
	logic start_rise;

	// Only a fresh rise counts, a held level does not
	assign start_rise = start && !start_q;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_q        <= 1'b0;
			sample         <= 1'b0;
			latched_target <= '0;
			latched_imu    <= '0;
			latched_err    <= '0;
		end else begin
			start_q <= start;
			sample  <= 1'b0;
			if (start_rise && !busy) begin
				sample         <= 1'b1;
				latched_target <= target;
				latched_err    <= angle_err;
				// IMU yaw and pitch axes point opposite to the body frame
				latched_imu.yaw   <= -imu_rate.yaw;
				latched_imu.roll  <= imu_rate.roll;
				latched_imu.pitch <= -imu_rate.pitch;
			end
		end
	end

endmodule

/* hdl/rate_loop_control.sv */
// Rate loop sequencer
// Launches the three PID axes after a sample and reports completion
// once every axis has finished

module rate_loop_control (
	input  logic us_clk,
	input  logic resetn,
	input  logic sample,
	input  logic done_yaw,
	input  logic done_roll,
	input  logic done_pitch,
	output logic go,
	output logic busy,
	output logic complete
);

	rate_ctrl_pkg::ctrl_state_e state;
	rate_ctrl_pkg::ctrl_state_e next_state;

	// Yaw, roll, pitch
	logic [2:0] done_flags;
	logic [2:0] done_seen;

	// Flags plus any report arriving this cycle
	assign done_seen = done_flags | {done_yaw, done_roll, done_pitch};

	always_comb begin
		next_state = state;
		case (state)
			rate_ctrl_pkg::CTRL_IDLE: begin
				if (sample)
					next_state = rate_ctrl_pkg::CTRL_RUN;
			end
			rate_ctrl_pkg::CTRL_RUN: begin
				if (&done_seen)
					next_state = rate_ctrl_pkg::CTRL_DONE;
			end
			default: begin
				next_state = rate_ctrl_pkg::CTRL_IDLE;
			end
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state      <= rate_ctrl_pkg::CTRL_IDLE;
			go         <= 1'b0;
			done_flags <= '0;
		end else begin
			state <= next_state;
			// Single go pulse on entry to RUN
			go    <= (state == rate_ctrl_pkg::CTRL_IDLE) && sample;
			if (state == rate_ctrl_pkg::CTRL_RUN)
				done_flags <= done_seen;
			else
				done_flags <= '0;
		end
	end

	// Blocks new samples until the cycle has wrapped up
	assign busy     = sample || (state != rate_ctrl_pkg::CTRL_IDLE);
	assign complete = (state == rate_ctrl_pkg::CTRL_DONE);

endmodule

/* rate_pid/rate_pid.sv */
// One PID axis of the rate loop
// Four-step sequence per go pulse: error, gain terms, sum, saturation.
// The integral is clamped and the command is limited to RATE_MIN..RATE_MAX

`include "rate_ctrl_defs.svh"

module rate_pid #(
	parameter rate_ctrl_pkg::ops_t K_P       = 1,
	parameter rate_ctrl_pkg::ops_t K_I       = 0,
	parameter rate_ctrl_pkg::ops_t K_D       = 0,
	parameter int unsigned         K_P_SHIFT = 0,
	parameter int unsigned         K_I_SHIFT = 0,
	parameter int unsigned         K_D_SHIFT = 0,
	parameter rate_ctrl_pkg::ops_t RATE_MIN  = -(`RATE_LIMIT),
	parameter rate_ctrl_pkg::ops_t RATE_MAX  = `RATE_LIMIT
) (
	input  logic                 us_clk,
	input  logic                 resetn,
	input  logic                 go,
	input  rate_ctrl_pkg::rate_t target,
	input  rate_ctrl_pkg::rate_t actual,
	input  rate_ctrl_pkg::rate_t angle_error,
	output rate_ctrl_pkg::rate_t rate_out,
	output logic                 done
);

	localparam rate_ctrl_pkg::ops_t INT_MAX = `INT_LIMIT;

	rate_ctrl_pkg::pid_state_e state;

	// Carried from one control cycle to the next
	rate_ctrl_pkg::ops_t integral;
	rate_ctrl_pkg::ops_t prev_error;

	// Per-cycle working values
	rate_ctrl_pkg::ops_t error;
	rate_ctrl_pkg::ops_t d_error;
	rate_ctrl_pkg::ops_t p_term;
	rate_ctrl_pkg::ops_t i_term;
	rate_ctrl_pkg::ops_t d_term;
	rate_ctrl_pkg::ops_t sum;

	rate_ctrl_pkg::ops_t err_now;
	rate_ctrl_pkg::ops_t int_sum;
	rate_ctrl_pkg::ops_t int_next;
	rate_ctrl_pkg::ops_t sat_sum;

	assign err_now = rate_ctrl_pkg::ops_t'(target) - rate_ctrl_pkg::ops_t'(actual);
	assign int_sum = integral + rate_ctrl_pkg::ops_t'(angle_error);

	// Anti-windup clamp
	always_comb begin
		if (int_sum > INT_MAX)
			int_next = INT_MAX;
		else if (int_sum < -INT_MAX)
			int_next = -INT_MAX;
		else
			int_next = int_sum;
	end

	// Output limit
	always_comb begin
		if (sum > RATE_MAX)
			sat_sum = RATE_MAX;
		else if (sum < RATE_MIN)
			sat_sum = RATE_MIN;
		else
			sat_sum = sum;
	end

	// Sequence, history and result
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state      <= rate_ctrl_pkg::PID_IDLE;
			integral   <= '0;
			prev_error <= '0;
			rate_out   <= '0;
			done       <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				rate_ctrl_pkg::PID_IDLE: begin
					if (go)
						state <= rate_ctrl_pkg::PID_ERR;
				end
				rate_ctrl_pkg::PID_ERR: begin
					integral <= int_next;
					state    <= rate_ctrl_pkg::PID_TERMS;
				end
				rate_ctrl_pkg::PID_TERMS: begin
					state <= rate_ctrl_pkg::PID_SUM;
				end
				rate_ctrl_pkg::PID_SUM: begin
					state <= rate_ctrl_pkg::PID_SAT;
				end
				rate_ctrl_pkg::PID_SAT: begin
					rate_out   <= rate_ctrl_pkg::rate_t'(sat_sum);
					prev_error <= error;
					done       <= 1'b1;
					state      <= rate_ctrl_pkg::PID_IDLE;
				end
				default: begin
					state <= rate_ctrl_pkg::PID_IDLE;
				end
			endcase
		end
	end

	// Arithmetic pipeline, stepped by the sequence
	always_ff @(posedge us_clk) begin
		case (state)
			rate_ctrl_pkg::PID_ERR: begin
				error   <= err_now;
				d_error <= err_now - prev_error;
			end
			rate_ctrl_pkg::PID_TERMS: begin
				p_term <= (error * K_P) >>> K_P_SHIFT;
				i_term <= (integral * K_I) >>> K_I_SHIFT;
				d_term <= (d_error * K_D) >>> K_D_SHIFT;
			end
			rate_ctrl_pkg::PID_SUM: begin
				sum <= p_term + i_term + d_term;
			end
			default: begin
			end
		endcase
	end

endmodule

/* hdl/body_rate_controller.sv */
// Body-frame rate controller
// Samples targets and IMU rates on a start rise, runs a PID per axis
// and returns saturated rate commands with a complete pulse

`include "rate_ctrl_defs.svh"

module body_rate_controller (
	input  logic                            us_clk,
	input  logic                            resetn,
	input  logic                            start,
	input  rate_ctrl_pkg::axis_rates_t      target,
	input  rate_ctrl_pkg::axis_rates_t      imu_rate,
	input  rate_ctrl_pkg::angle_err_t       angle_err,
	output wire rate_ctrl_pkg::axis_rates_t rate_cmd,
	output logic                            complete
);

	rate_ctrl_pkg::axis_rates_t latched_target;
	rate_ctrl_pkg::axis_rates_t latched_imu;
	rate_ctrl_pkg::angle_err_t  latched_err;

	logic sample;
	logic busy;
	logic go;
	logic done_yaw;
	logic done_roll;
	logic done_pitch;

	rate_sample_latch latch (
		.us_clk        (us_clk),
		.resetn        (resetn),
		.start         (start),
		.target        (target),
		.imu_rate      (imu_rate),
		.angle_err     (angle_err),
		.busy          (busy),
		.latched_target(latched_target),
		.latched_imu   (latched_imu),
		.latched_err   (latched_err),
		.sample        (sample)
	);

	rate_loop_control control (
		.us_clk    (us_clk),
		.resetn    (resetn),
		.sample    (sample),
		.done_yaw  (done_yaw),
		.done_roll (done_roll),
		.done_pitch(done_pitch),
		.go        (go),
		.busy      (busy),
		.complete  (complete)
	);

	// Yaw has no angle loop input
	rate_pid #(
		.K_P(`YAW_K_P), .K_I(`YAW_K_I), .K_D(`YAW_K_D),
		.K_P_SHIFT(`YAW_K_P_SHIFT), .K_I_SHIFT(`YAW_K_I_SHIFT), .K_D_SHIFT(`YAW_K_D_SHIFT),
		.RATE_MIN(-(`RATE_LIMIT)), .RATE_MAX(`RATE_LIMIT)
	) yaw_pid (
		.us_clk(us_clk), .resetn(resetn), .go(go),
		.target(latched_target.yaw), .actual(latched_imu.yaw), .angle_error('0),
		.rate_out(rate_cmd.yaw), .done(done_yaw)
	);

	rate_pid #(
		.K_P(`ROLL_K_P), .K_I(`ROLL_K_I), .K_D(`ROLL_K_D),
		.K_P_SHIFT(`ROLL_K_P_SHIFT), .K_I_SHIFT(`ROLL_K_I_SHIFT), .K_D_SHIFT(`ROLL_K_D_SHIFT),
		.RATE_MIN(-(`RATE_LIMIT)), .RATE_MAX(`RATE_LIMIT)
	) roll_pid (
		.us_clk(us_clk), .resetn(resetn), .go(go),
		.target(latched_target.roll), .actual(latched_imu.roll),
		.angle_error(latched_err.roll),
		.rate_out(rate_cmd.roll), .done(done_roll)
	);

	rate_pid #(
		.K_P(`PITCH_K_P), .K_I(`PITCH_K_I), .K_D(`PITCH_K_D),
		.K_P_SHIFT(`PITCH_K_P_SHIFT), .K_I_SHIFT(`PITCH_K_I_SHIFT), .K_D_SHIFT(`PITCH_K_D_SHIFT),
		.RATE_MIN(-(`RATE_LIMIT)), .RATE_MAX(`RATE_LIMIT)
	) pitch_pid (
		.us_clk(us_clk), .resetn(resetn), .go(go),
		.target(latched_target.pitch), .actual(latched_imu.pitch),
		.angle_error(latched_err.pitch),
		.rate_out(rate_cmd.pitch), .done(done_pitch)
	);

endmodule

/* sim/body_rate_controller_sva.sv */
// Handshake checks for the body rate controller
// Bound into the top level, watches go, busy and complete

module body_rate_controller_sva (
	input logic us_clk,
	input logic resetn,
	input logic go,
	input logic busy,
	input logic complete
);
	timeunit 1ns;
	timeprecision 100ps;

	// Complete is a single-cycle pulse
	complete_one_cycle: assert property (@(posedge us_clk) disable iff (!resetn)
		complete |=> !complete)
		else $error("complete stayed high for more than one cycle");

	// Fixed latency from go to complete
	complete_after_go: assert property (@(posedge us_clk) disable iff (!resetn)
		go |-> ##6 complete)
		else $error("complete did not follow go after six cycles");

	// A new cycle only launches from idle
	go_from_idle: assert property (@(posedge us_clk) disable iff (!resetn)
		go |-> $past(!busy, 2))
		else $error("go issued while a cycle was already running");

endmodule

bind body_rate_controller body_rate_controller_sva handshake_checks (
	.us_clk  (us_clk),
	.resetn  (resetn),
	.go      (go),
	.busy    (busy),
	.complete(complete)
);

/* sim/body_rate_controller_tb.sv */
// Testbench for the body rate controller
// Table-driven control cycles checked against a per-axis PID reference model

`include "rate_ctrl_defs.svh"

module body_rate_controller_tb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		rate_ctrl_pkg::axis_rates_t target;
		rate_ctrl_pkg::axis_rates_t imu;
		rate_ctrl_pkg::angle_err_t  err;
		logic                       retrigger;
	} entry_t;

	logic                       us_clk = 1'b0;
	logic                       resetn;
	logic                       start;
	rate_ctrl_pkg::axis_rates_t target;
	rate_ctrl_pkg::axis_rates_t imu_rate;
	rate_ctrl_pkg::angle_err_t  angle_err;
	rate_ctrl_pkg::axis_rates_t rate_cmd;
	logic                       complete;

	entry_t table_q[$];
	int     seed = 76;

	// Model state, index 0 yaw, 1 roll, 2 pitch
	int integ[3];
	int prev_err[3];
	int exp_cmd[3];
	int kp[3]  = '{`YAW_K_P, `ROLL_K_P, `PITCH_K_P};
	int ki[3]  = '{`YAW_K_I, `ROLL_K_I, `PITCH_K_I};
	int kd[3]  = '{`YAW_K_D, `ROLL_K_D, `PITCH_K_D};
	int kps[3] = '{`YAW_K_P_SHIFT, `ROLL_K_P_SHIFT, `PITCH_K_P_SHIFT};
	int kis[3] = '{`YAW_K_I_SHIFT, `ROLL_K_I_SHIFT, `PITCH_K_I_SHIFT};
	int kds[3] = '{`YAW_K_D_SHIFT, `ROLL_K_D_SHIFT, `PITCH_K_D_SHIFT};

	body_rate_controller uut (
		.us_clk   (us_clk),
		.resetn   (resetn),
		.start    (start),
		.target   (target),
		.imu_rate (imu_rate),
		.angle_err(angle_err),
		.rate_cmd (rate_cmd),
		.complete (complete)
	);

	always #2 us_clk = ~us_clk;

	function automatic int to_int(input rate_ctrl_pkg::rate_t v);
		return int'(v);
	endfunction

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected)
		else begin
			$display("FAIL at %0t ns: %s expected %0d, actual %0d", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_outputs();
		check_value("rate_cmd.yaw", exp_cmd[0], to_int(rate_cmd.yaw));
		check_value("rate_cmd.roll", exp_cmd[1], to_int(rate_cmd.roll));
		check_value("rate_cmd.pitch", exp_cmd[2], to_int(rate_cmd.pitch));
	endtask

	task automatic add_entry(input int ty, tr, tp, iy, ir, ip, er, ep, rt);
		entry_t e;
		e.target    = {rate_ctrl_pkg::rate_t'(ty), rate_ctrl_pkg::rate_t'(tr),
			rate_ctrl_pkg::rate_t'(tp)};
		e.imu       = {rate_ctrl_pkg::rate_t'(iy), rate_ctrl_pkg::rate_t'(ir),
			rate_ctrl_pkg::rate_t'(ip)};
		e.err       = {rate_ctrl_pkg::rate_t'(er), rate_ctrl_pkg::rate_t'(ep)};
		e.retrigger = (rt != 0);
		table_q.push_back(e);
	endtask

	// PID rule per axis, IMU yaw and pitch flipped into the body frame
	task automatic model_step(input entry_t e);
		int tgt[3];
		int act[3];
		int ang[3];
		int err;
		int d_err;
		int sum;
		int a;
		tgt = '{to_int(e.target.yaw), to_int(e.target.roll), to_int(e.target.pitch)};
		act = '{-to_int(e.imu.yaw), to_int(e.imu.roll), -to_int(e.imu.pitch)};
		ang = '{0, to_int(e.err.roll), to_int(e.err.pitch)};
		for (a = 0; a < 3; a++) begin
			err   = tgt[a] - act[a];
			d_err = err - prev_err[a];
			integ[a] = integ[a] + ang[a];
			if (integ[a] > `INT_LIMIT)
				integ[a] = `INT_LIMIT;
			else if (integ[a] < -(`INT_LIMIT))
				integ[a] = -(`INT_LIMIT);
			sum = ((err * kp[a]) >>> kps[a]) + ((integ[a] * ki[a]) >>> kis[a])
				+ ((d_err * kd[a]) >>> kds[a]);
			if (sum > `RATE_LIMIT)
				sum = `RATE_LIMIT;
			else if (sum < -(`RATE_LIMIT))
				sum = -(`RATE_LIMIT);
			exp_cmd[a]  = sum;
			prev_err[a] = err;
		end
	endtask

	task automatic build_table();
		int n;
		add_entry(0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_entry(80, -48, 32, 16, 24, -40, 100, -60, 0);
		// Equal target and IMU, only roll sees no error
		add_entry(160, 160, 160, 160, 160, 160, 0, 0, 1);
		// Saturation both ways
		add_entry(8000, 8000, 8000, 8000, -8000, 8000, 0, 0, 0);
		add_entry(-8000, -8000, -8000, -8000, 8000, -8000, 0, 0, 1);
		// Constant angle error winds the integral up to its clamp
		for (n = 0; n < 18; n++)
			add_entry(0, 0, 0, 0, 0, 0, 4000, -4000, n % 2);
		// Opposite error unwinds from the clamp past zero
		for (n = 0; n < 18; n++)
			add_entry(0, 0, 0, 0, 0, 0, -4000, 4000, 0);
		for (n = 0; n < 12; n++)
			add_entry($random(seed) % 2000, $random(seed) % 2000, $random(seed) % 2000,
				$random(seed) % 2000, $random(seed) % 2000, $random(seed) % 2000,
				$random(seed) % 3000, $random(seed) % 3000, $random(seed) & 1);
	endtask

	// Called 1 ns after a rising edge with start low
	task automatic run_entry(input entry_t e);
		int cycles;
		cycles    = 0;
		target    = e.target;
		imu_rate  = e.imu;
		angle_err = e.err;
		start     = 1'b1;
		model_step(e);
		@(posedge us_clk);
		#1;
		while (!complete) begin
			cycles++;
			if (cycles == 50) begin
				$display("Timeout: complete did not pulse within 50 cycles");
				abort_run();
			end
			// Drop start so it rises again on the edge that leaves DONE
			if (e.retrigger && cycles == 7)
				start = 1'b0;
			@(posedge us_clk);
			#1;
		end
		// Second rise while the control is still busy
		start = 1'b1;
		check_outputs();
		// Start still held, nothing may retrigger and rate_cmd must hold
		repeat (10) begin
			@(posedge us_clk);
			#1;
			check_value("complete", 0, int'(complete));
			check_outputs();
		end
		start = 1'b0;
		@(posedge us_clk);
		#1;
		check_outputs();
	endtask

	initial begin
		resetn    = 1'b0;
		start     = 1'b0;
		target    = '0;
		imu_rate  = '0;
		angle_err = '0;
		build_table();
		repeat (3) @(posedge us_clk);
		#1;
		resetn = 1'b1;
		repeat (4) begin
			@(posedge us_clk);
			#1;
			check_value("complete", 0, int'(complete));
			check_outputs();
		end
		foreach (table_q[i])
			run_entry(table_q[i]);
		$display(">>> PASS");
		$finish;
	end

endmodule

/* body_rate_controller.f */
+incdir+common
common/rate_ctrl_pkg.sv
hdl/rate_sample_latch.sv
hdl/rate_loop_control.sv
rate_pid/rate_pid.sv
hdl/body_rate_controller.sv
sim/body_rate_controller_sva.sv
sim/body_rate_controller_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the body rate controller testbench with Verilator, run it, check the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f body_rate_controller.f \
	--top-module body_rate_controller_tb -o sim_tb &&
./obj_dir/sim_tb > sim.log 2>&1 ;
cat sim.log &&
! grep -q -e ">>> FAIL" -e "%Error" sim.log &&
echo "Simulation finished without errors" ||
{ echo "Simulation reported errors"; exit 1; }
